/* design/id_pkg.sv */
/*
 * Shared widths, major opcodes and select encodings of the RV32I decode stage.
 */
package id_pkg;

	localparam int unsigned XLEN       = 32;
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned NUM_REGS   = 32;

	// funct7 patterns of the base and alternate (SUB, SRA) encodings.
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

	// Major opcodes handled by the stage, taken from instr[6:0].
	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'h03,
		OPCODE_OP_IMM = 7'h13,
		OPCODE_AUIPC  = 7'h17,
		OPCODE_STORE  = 7'h23,
		OPCODE_OP     = 7'h33,
		OPCODE_LUI    = 7'h37
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_XOR  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_AND  = 4'd4,
		ALU_SRA  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		OP_A_REG_A  = 2'd0,
		OP_A_CURRPC = 2'd1,
		OP_A_ZERO   = 2'd2
	} op_a_sel_e;

	typedef enum logic {
		OP_B_REG_B = 1'b0,
		OP_B_IMM   = 1'b1
	} op_b_sel_e;

	typedef enum logic [1:0] {
		IMM_B_I = 2'd0,
		IMM_B_S = 2'd1,
		IMM_B_U = 2'd2
	} imm_b_sel_e;

	// Source of the register write data.
	typedef enum logic {
		RF_WD_EX  = 1'b0,
		RF_WD_LSU = 1'b1
	} rf_wd_sel_e;

	// Access size, same coding as the LSU expects.
	typedef enum logic [1:0] {
		DATA_WORD = 2'b00,
		DATA_HALF = 2'b01,
		DATA_BYTE = 2'b10
	} data_type_e;

	typedef enum logic {
		IDLE     = 1'b0,
		WAIT_LSU = 1'b1  // A load or store waits for the LSU response.
	} wb_state_e;

endpackage

/* design/id_decoder.sv */
/*
 * Instruction decoder. Turns opcode, funct3 and funct7 into operand selects,
 * register addresses, LSU controls and the illegal flag.
 */
module id_decoder (
	input  logic                              instr_valid_i,
	input  logic [id_pkg::XLEN-1:0]           instr_rdata_i,
	output logic                              illegal_insn_o,
	output id_pkg::alu_op_e                   alu_operator_o,
	output id_pkg::op_a_sel_e                 op_a_sel_o,
	output id_pkg::op_b_sel_e                 op_b_sel_o,
	output id_pkg::imm_b_sel_e                imm_b_sel_o,
	output logic [id_pkg::REG_ADDR_W-1:0]     rf_raddr_a_o,
	output logic [id_pkg::REG_ADDR_W-1:0]     rf_raddr_b_o,
	output logic [id_pkg::REG_ADDR_W-1:0]     rf_waddr_o,
	output logic                              rf_we_o,
	output id_pkg::rf_wd_sel_e                rf_wd_sel_o,
	output logic                              data_req_o,
	output logic                              data_we_o,
	output logic                              data_sign_ext_o,
	output id_pkg::data_type_e                data_type_o
);

	id_pkg::opcode_e opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic            illegal;

	// Shared funct3 to ALU operation map of OP and OP_IMM.
	function automatic id_pkg::alu_op_e alu_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
			3'b001:  alu_op = id_pkg::ALU_SLL;
			3'b010:  alu_op = id_pkg::ALU_SLT;
			3'b011:  alu_op = id_pkg::ALU_SLTU;
			3'b100:  alu_op = id_pkg::ALU_XOR;
			3'b101:  alu_op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
			3'b110:  alu_op = id_pkg::ALU_OR;
			default: alu_op = id_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = id_pkg::opcode_e'(instr_rdata_i[6:0]);
	assign funct3 = instr_rdata_i[14:12];
	assign funct7 = instr_rdata_i[31:25];

	assign rf_raddr_a_o = instr_rdata_i[19:15];
	assign rf_raddr_b_o = instr_rdata_i[24:20];
	assign rf_waddr_o   = instr_rdata_i[11:7];

	always_comb begin
		illegal         = 1'b0;
		alu_operator_o  = id_pkg::ALU_ADD;
		op_a_sel_o      = id_pkg::OP_A_REG_A;
		op_b_sel_o      = id_pkg::OP_B_REG_B;
		imm_b_sel_o     = id_pkg::IMM_B_I;
		rf_we_o         = 1'b0;
		rf_wd_sel_o     = id_pkg::RF_WD_EX;
		data_req_o      = 1'b0;
		data_we_o       = 1'b0;
		data_sign_ext_o = 1'b0;
		data_type_o     = id_pkg::DATA_WORD;

		case (opcode)
			id_pkg::OPCODE_OP: begin
				rf_we_o        = 1'b1;
				alu_operator_o = alu_op(funct3, funct7 == id_pkg::FUNCT7_ALT);
				if (funct7 == id_pkg::FUNCT7_ALT) begin
					illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
				end else begin
					illegal = funct7 != id_pkg::FUNCT7_BASE;
				end
			end
			id_pkg::OPCODE_OP_IMM: begin
				rf_we_o    = 1'b1;
				op_b_sel_o = id_pkg::OP_B_IMM;
				// Bit 30 only selects SRAI; for ADDI it is part of the immediate.
				alu_operator_o = alu_op(funct3, (funct3 == 3'b101) &&
					(funct7 == id_pkg::FUNCT7_ALT));
				if (funct3 == 3'b001) begin
					illegal = funct7 != id_pkg::FUNCT7_BASE;
				end else if (funct3 == 3'b101) begin
					illegal = (funct7 != id_pkg::FUNCT7_BASE) && (funct7 != id_pkg::FUNCT7_ALT);
				end
			end
			id_pkg::OPCODE_LUI, id_pkg::OPCODE_AUIPC: begin
				rf_we_o     = 1'b1;
				op_b_sel_o  = id_pkg::OP_B_IMM;
				imm_b_sel_o = id_pkg::IMM_B_U;
				op_a_sel_o  = (opcode == id_pkg::OPCODE_LUI) ? id_pkg::OP_A_ZERO :
					id_pkg::OP_A_CURRPC;
			end
			id_pkg::OPCODE_LOAD, id_pkg::OPCODE_STORE: begin
				data_req_o      = 1'b1;
				data_we_o       = opcode == id_pkg::OPCODE_STORE;
				rf_we_o         = opcode == id_pkg::OPCODE_LOAD;
				rf_wd_sel_o     = id_pkg::RF_WD_LSU;
				op_b_sel_o      = id_pkg::OP_B_IMM;
				imm_b_sel_o     = data_we_o ? id_pkg::IMM_B_S : id_pkg::IMM_B_I;
				data_sign_ext_o = ~funct3[2];
				case (funct3[1:0])
					2'b00:   data_type_o = id_pkg::DATA_BYTE;
					2'b01:   data_type_o = id_pkg::DATA_HALF;
					2'b10:   data_type_o = id_pkg::DATA_WORD;
					default: illegal     = 1'b1;
				endcase
				// Stores have no unsigned forms.
				if (data_we_o && funct3[2]) begin
					illegal = 1'b1;
				end
				if (!data_we_o && funct3 == 3'b110) begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase

		if (illegal) begin
			rf_we_o    = 1'b0;
			data_req_o = 1'b0;
			data_we_o  = 1'b0;
		end
	end

	assign illegal_insn_o = instr_valid_i & illegal;

endmodule

/* design/id_regfile.sv */
/*
 * Register file with 31 writable 32-bit registers, two read ports and one
 * write port. x0 always reads zero.
 */
module id_regfile (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic [id_pkg::REG_ADDR_W-1:0] raddr_a_i,
	input  logic [id_pkg::REG_ADDR_W-1:0] raddr_b_i,
	input  logic [id_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [id_pkg::XLEN-1:0]       wdata_i,
	input  logic                          we_i,
	output logic [id_pkg::XLEN-1:0]       rdata_a_o,
	output logic [id_pkg::XLEN-1:0]       rdata_b_o
);

	logic [id_pkg::XLEN-1:0] regs_q [1:id_pkg::NUM_REGS-1];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < id_pkg::NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin  // Writes to x0 are dropped.
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

	// The write enable comes from the writeback FSM and must be clean every cycle.
	assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(we_i))
		else $error("Register file write enable is unknown.");

endmodule

/* design/id_operand_mux.sv */
/*
 * Immediate extraction and ALU operand selection.
 */
module id_operand_mux (
	input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
	input  logic [id_pkg::XLEN-1:0] pc_i,
	input  logic [id_pkg::XLEN-1:0] rdata_a_i,
	input  logic [id_pkg::XLEN-1:0] rdata_b_i,
	input  id_pkg::op_a_sel_e       op_a_sel_i,
	input  id_pkg::op_b_sel_e       op_b_sel_i,
	input  id_pkg::imm_b_sel_e      imm_b_sel_i,
	output logic [id_pkg::XLEN-1:0] alu_operand_a_o,
	output logic [id_pkg::XLEN-1:0] alu_operand_b_o
);

	logic [id_pkg::XLEN-1:0] imm_i_type;
	logic [id_pkg::XLEN-1:0] imm_s_type;
	logic [id_pkg::XLEN-1:0] imm_u_type;
	logic [id_pkg::XLEN-1:0] imm_b;

	assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
	assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
	assign imm_u_type = {instr_rdata_i[31:12], 12'b0};

	always_comb begin
		case (op_a_sel_i)
			id_pkg::OP_A_CURRPC: alu_operand_a_o = pc_i;
			id_pkg::OP_A_ZERO:   alu_operand_a_o = '0;  // LUI adds the immediate to zero.
			default:             alu_operand_a_o = rdata_a_i;
		endcase
	end

	always_comb begin
		case (imm_b_sel_i)
			id_pkg::IMM_B_S: imm_b = imm_s_type;
			id_pkg::IMM_B_U: imm_b = imm_u_type;
			default:         imm_b = imm_i_type;
		endcase
	end

	assign alu_operand_b_o = (op_b_sel_i == id_pkg::OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

/* design/id_wb_fsm.sv */
/*
 * Writeback FSM. Single-cycle instructions retire at once; a load or store
 * keeps fetch stalled until the LSU answers, then writes back and retires.
 */
module id_wb_fsm (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic instr_valid_i,
	input  logic data_req_i,
	input  logic rf_we_i,
	input  logic lsu_valid_i,
	input  logic illegal_i,
	output logic id_ready_o,
	output logic data_req_o,
	output logic rf_we_o,
	output logic instr_ret_o
);

	id_pkg::wb_state_e state_q;
	id_pkg::wb_state_e state_d;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= id_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d     = state_q;
		id_ready_o  = 1'b1;
		data_req_o  = 1'b0;
		rf_we_o     = 1'b0;
		instr_ret_o = 1'b0;

		case (state_q)
			id_pkg::IDLE: begin
				if (instr_valid_i) begin
					if (data_req_i && !illegal_i) begin
						// The word stays with fetch, so rd is still decoded at writeback.
						data_req_o = 1'b1;
						id_ready_o = 1'b0;
						state_d    = id_pkg::WAIT_LSU;
					end else begin
						rf_we_o     = rf_we_i & ~illegal_i;
						instr_ret_o = ~illegal_i;  // An illegal word is consumed silently.
					end
				end
			end
			id_pkg::WAIT_LSU: begin
				id_ready_o = lsu_valid_i;
				if (lsu_valid_i) begin
					rf_we_o     = rf_we_i;  // Only loads have it set.
					instr_ret_o = 1'b1;
					state_d     = id_pkg::IDLE;
				end
			end
			default: state_d = id_pkg::IDLE;
		endcase
	end

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		lsu_valid_i |-> (state_q == id_pkg::WAIT_LSU))
		else $error("LSU response arrived with no access outstanding.");

endmodule

/* design/id_stage.sv */
/*
 * RV32I decode stage top. Connects decoder, register file, operand mux and
 * writeback FSM, and picks the register write data.
 */
module id_stage (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  logic                      instr_valid_i,
	input  logic [id_pkg::XLEN-1:0]   instr_rdata_i,
	input  logic [id_pkg::XLEN-1:0]   pc_i,
	input  logic [id_pkg::XLEN-1:0]   alu_result_i,
	input  logic                      lsu_valid_i,
	input  logic [id_pkg::XLEN-1:0]   lsu_rdata_i,
	output logic                      id_ready_o,
	output logic                      illegal_insn_o,
	output logic                      instr_ret_o,
	output id_pkg::alu_op_e           alu_operator_o,
	output logic [id_pkg::XLEN-1:0]   alu_operand_a_o,
	output logic [id_pkg::XLEN-1:0]   alu_operand_b_o,
	output logic                      data_req_o,
	output logic                      data_we_o,
	output id_pkg::data_type_e        data_type_o,
	output logic                      data_sign_ext_o,
	output logic [id_pkg::XLEN-1:0]   data_wdata_o
);

	logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a;
	logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b;
	logic [id_pkg::REG_ADDR_W-1:0] rf_waddr;
	logic [id_pkg::XLEN-1:0]       rf_rdata_a;
	logic [id_pkg::XLEN-1:0]       rf_rdata_b;
	logic [id_pkg::XLEN-1:0]       rf_wdata;
	logic                          rf_we_dec;
	logic                          rf_we;
	id_pkg::rf_wd_sel_e            rf_wd_sel;
	id_pkg::op_a_sel_e             op_a_sel;
	id_pkg::op_b_sel_e             op_b_sel;
	id_pkg::imm_b_sel_e            imm_b_sel;
	logic                          data_req_dec;

	id_decoder decoder_i (
		.instr_valid_i   (instr_valid_i),
		.instr_rdata_i   (instr_rdata_i),
		.illegal_insn_o  (illegal_insn_o),
		.alu_operator_o  (alu_operator_o),
		.op_a_sel_o      (op_a_sel),
		.op_b_sel_o      (op_b_sel),
		.imm_b_sel_o     (imm_b_sel),
		.rf_raddr_a_o    (rf_raddr_a),
		.rf_raddr_b_o    (rf_raddr_b),
		.rf_waddr_o      (rf_waddr),
		.rf_we_o         (rf_we_dec),
		.rf_wd_sel_o     (rf_wd_sel),
		.data_req_o      (data_req_dec),
		.data_we_o       (data_we_o),
		.data_sign_ext_o (data_sign_ext_o),
		.data_type_o     (data_type_o)
	);

	// Loads write the LSU data, everything else the execute result.
	assign rf_wdata = (rf_wd_sel == id_pkg::RF_WD_LSU) ? lsu_rdata_i : alu_result_i;

	id_regfile regfile_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.raddr_a_i (rf_raddr_a),
		.raddr_b_i (rf_raddr_b),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.we_i      (rf_we),
		.rdata_a_o (rf_rdata_a),
		.rdata_b_o (rf_rdata_b)
	);

	id_operand_mux operand_mux_i (
		.instr_rdata_i   (instr_rdata_i),
		.pc_i            (pc_i),
		.rdata_a_i       (rf_rdata_a),
		.rdata_b_i       (rf_rdata_b),
		.op_a_sel_i      (op_a_sel),
		.op_b_sel_i      (op_b_sel),
		.imm_b_sel_i     (imm_b_sel),
		.alu_operand_a_o (alu_operand_a_o),
		.alu_operand_b_o (alu_operand_b_o)
	);

	id_wb_fsm wb_fsm_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.instr_valid_i (instr_valid_i),
		.data_req_i    (data_req_dec),
		.rf_we_i       (rf_we_dec),
		.lsu_valid_i   (lsu_valid_i),
		.illegal_i     (illegal_insn_o),
		.id_ready_o    (id_ready_o),
		.data_req_o    (data_req_o),
		.rf_we_o       (rf_we),
		.instr_ret_o   (instr_ret_o)
	);

	assign data_wdata_o = rf_rdata_b;  // Store data is rs2.

endmodule

/* include/tb_id_model.svh */
/*
 * Reference model of the decode stage testbench. Holds the LCG, the random
 * instruction generator and a shadow copy of the register file.
 */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

typedef enum int {K_OP, K_OP_IMM, K_LUI, K_AUIPC, K_LOAD, K_STORE, K_ILLEGAL} kind_e;

logic [31:0]        lcg_state = 32'd3;
logic [31:0]        shadow_regs [0:31];
int                 model_retires = 0;
kind_e              exp_kind;
logic [4:0]         exp_rd;
logic [4:0]         exp_rs1;
logic [4:0]         exp_rs2;
logic [31:0]        exp_imm;
logic               exp_sign;
id_pkg::alu_op_e    exp_op;
id_pkg::data_type_e exp_type;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// The low LCG bits repeat quickly, so only the upper half is used.
function automatic int unsigned rand_below(input int unsigned n);
	logic [31:0] r;
	r = lcg_next();
	return {16'd0, r[31:16]} % n;
endfunction

function automatic logic [31:0] rand_word();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = lcg_next();
	lo = lcg_next();
	return {hi[31:16], lo[31:16]};
endfunction

// Mostly x0 to x7, so results are read back soon after they are written.
function automatic logic [4:0] pick_reg();
	if (rand_below(4) == 0)
		return 5'(rand_below(32));
	return 5'(rand_below(8));
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

// Picks an ALU operation and gives its RV32I funct3 and funct7.
task automatic pick_alu_op(input logic is_reg, output logic [2:0] f3, output logic [6:0] f7);
	int unsigned k;
	k = rand_below(is_reg ? 10 : 9);
	if (!is_reg && k >= 1)
		k++;  // There is no SUBI.
	exp_op = id_pkg::alu_op_e'(k[3:0]);
	case (exp_op)
		id_pkg::ALU_ADD, id_pkg::ALU_SUB: f3 = 3'b000;
		id_pkg::ALU_SLL:                  f3 = 3'b001;
		id_pkg::ALU_SLT:                  f3 = 3'b010;
		id_pkg::ALU_SLTU:                 f3 = 3'b011;
		id_pkg::ALU_XOR:                  f3 = 3'b100;
		id_pkg::ALU_SRL, id_pkg::ALU_SRA: f3 = 3'b101;
		id_pkg::ALU_OR:                   f3 = 3'b110;
		default:                          f3 = 3'b111;
	endcase
	f7 = (exp_op == id_pkg::ALU_SUB || exp_op == id_pkg::ALU_SRA) ? 7'b0100000 : 7'b0000000;
endtask

task automatic gen_instr(output logic [31:0] word);
	int unsigned sel;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [11:0] imm12;
	sel = rand_below(16);
	exp_rd = pick_reg();
	exp_rs1 = pick_reg();
	exp_rs2 = pick_reg();
	imm12 = 12'(rand_below(4096));
	exp_sign = 1'b0;
	exp_type = id_pkg::DATA_WORD;
	if (sel < 4) begin
		exp_kind = K_OP;
		pick_alu_op(1'b1, f3, f7);
		word = {f7, exp_rs2, exp_rs1, f3, exp_rd, 7'h33};
	end else if (sel < 7) begin
		exp_kind = K_OP_IMM;
		pick_alu_op(1'b0, f3, f7);
		if (f3 == 3'b001 || f3 == 3'b101)
			imm12 = {f7, imm12[4:0]};  // Shifts keep funct7 above the shift amount.
		word = {imm12, exp_rs1, f3, exp_rd, 7'h13};
	end else if (sel < 9) begin
		exp_kind = (sel == 7) ? K_LUI : K_AUIPC;
		word = rand_word();
		word[11:0] = {exp_rd, (sel == 7) ? 7'h37 : 7'h17};
	end else if (sel < 14) begin
		exp_kind = (sel < 12) ? K_LOAD : K_STORE;
		f3 = 3'(rand_below(3));
		if (exp_kind == K_LOAD && f3 != 3'b010 && rand_below(2) == 0)
			f3[2] = 1'b1;  // LBU and LHU.
		exp_type = (f3[1:0] == 2'd0) ? id_pkg::DATA_BYTE :
			(f3[1:0] == 2'd1) ? id_pkg::DATA_HALF : id_pkg::DATA_WORD;
		exp_sign = !f3[2];
		if (exp_kind == K_LOAD)
			word = {imm12, exp_rs1, f3, exp_rd, 7'h03};
		else
			word = {imm12[11:5], exp_rs2, exp_rs1, f3, imm12[4:0], 7'h23};
	end else begin
		exp_kind = K_ILLEGAL;
		word = rand_word();
		case (rand_below(4))
			0: word[6:0] = 7'h63;  // Branch.
			1: word[6:0] = 7'h73;
			2: begin
				word[31:25] = 7'b0000001;  // MUL.
				word[6:0] = 7'h33;
			end
			default: begin
				word[14:12] = 3'b011;
				word[6:0] = 7'h03;
			end
		endcase
	end
	exp_imm = (exp_kind == K_LUI || exp_kind == K_AUIPC) ? {word[31:12], 12'h000} : sext12(imm12);
endtask

task automatic model_retire(input logic [31:0] wdata);
	if (exp_kind != K_STORE && exp_rd != 5'd0)
		shadow_regs[exp_rd] = wdata;
	model_retires++;
endtask

`endif

/* tests/tb_id_stage.sv */
/*
 * Testbench of the decode stage. Random instructions are checked against a
 * shadow register file, and an LSU model answers after a random delay.
 */
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INSTR      = 400;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 6 + 50;

	logic               clk_i;
	logic               rst_ni;
	logic               instr_valid_i;
	logic [31:0]        instr_rdata_i;
	logic [31:0]        pc_i;
	logic [31:0]        alu_result_i;
	logic               lsu_valid_i;
	logic [31:0]        lsu_rdata_i;
	logic               id_ready_o;
	logic               illegal_insn_o;
	logic               instr_ret_o;
	id_pkg::alu_op_e    alu_operator_o;
	logic [31:0]        alu_operand_a_o;
	logic [31:0]        alu_operand_b_o;
	logic               data_req_o;
	logic               data_we_o;
	id_pkg::data_type_e data_type_o;
	logic               data_sign_ext_o;
	logic [31:0]        data_wdata_o;

	int error_count = 0;
	int cycle_count = 0;
	int dut_retires = 0;

	`include "tb_id_model.svh"

	id_stage uut (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the stage stopped accepting instructions.", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			error_count++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			error_count++;
			$display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	// Decode outputs of the instruction on the bus, in its first cycle.
	task automatic check_decode();
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		exp_a = (exp_kind == K_LUI) ? 32'd0 : (exp_kind == K_AUIPC) ? pc_i : shadow_regs[exp_rs1];
		exp_b = (exp_kind == K_OP) ? shadow_regs[exp_rs2] : exp_imm;
		check_bit("illegal_insn_o", illegal_insn_o, exp_kind == K_ILLEGAL);
		if (exp_kind == K_ILLEGAL)
			return;
		if (exp_kind == K_OP || exp_kind == K_OP_IMM)
			check_value("alu_operator_o", 32'(alu_operator_o), 32'(exp_op));
		check_value("alu_operand_a_o", alu_operand_a_o, exp_a);
		check_value("alu_operand_b_o", alu_operand_b_o, exp_b);
		if (exp_kind == K_LOAD || exp_kind == K_STORE) begin
			check_bit("data_we_o", data_we_o, exp_kind == K_STORE);
			check_value("data_type_o", 32'(data_type_o), 32'(exp_type));
		end
		if (exp_kind == K_LOAD)
			check_bit("data_sign_ext_o", data_sign_ext_o, exp_sign);  // Only loads extend.
		if (exp_kind == K_STORE)
			check_value("data_wdata_o", data_wdata_o, shadow_regs[exp_rs2]);
	endtask

	initial begin
		logic [31:0] word;
		logic        is_mem;
		logic        first;
		logic        accepted;
		logic        exp_ret;
		logic        lsu_pending;
		int unsigned lsu_wait;
		int          ret_this;
		rst_ni = 1'b0;
		instr_valid_i = 1'b0;
		instr_rdata_i = '0;
		pc_i = '0;
		alu_result_i = '0;
		lsu_valid_i = 1'b0;
		lsu_rdata_i = '0;
		lsu_pending = 1'b0;
		lsu_wait = 0;
		foreach (shadow_regs[i])
			shadow_regs[i] = '0;
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		#40;
		check_bit("id_ready_o", id_ready_o, 1'b1);
		check_bit("data_req_o", data_req_o, 1'b0);
		check_bit("instr_ret_o", instr_ret_o, 1'b0);
		check_bit("illegal_insn_o", illegal_insn_o, 1'b0);

		for (int n = 0; n < NUM_INSTR; n++) begin
			gen_instr(word);
			is_mem = (exp_kind == K_LOAD || exp_kind == K_STORE);
			ret_this = 0;
			first = 1'b1;
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clk_i);
				if (first) begin
					instr_valid_i = 1'b1;
					instr_rdata_i = word;
					pc_i = rand_word();
					pc_i[1:0] = 2'b00;
				end
				alu_result_i = rand_word();
				lsu_rdata_i = rand_word();
				lsu_valid_i = lsu_pending && (lsu_wait == 0);  // LSU answers when its delay ran out.
				if (lsu_valid_i)
					lsu_pending = 1'b0;
				else if (lsu_pending)
					lsu_wait--;
				#40;
				exp_ret = is_mem ? lsu_valid_i : (first && exp_kind != K_ILLEGAL);
				if (first)
					check_decode();
				check_bit("data_req_o", data_req_o, is_mem && first);
				check_bit("id_ready_o", id_ready_o, !is_mem || lsu_valid_i);
				check_bit("instr_ret_o", instr_ret_o, exp_ret);
				if (instr_ret_o)
					ret_this++;
				if (data_req_o) begin
					lsu_pending = 1'b1;
					lsu_wait = rand_below(4);
				end
				if (exp_ret)
					model_retire((exp_kind == K_LOAD) ? lsu_rdata_i : alu_result_i);
				accepted = id_ready_o;
				first = 1'b0;
				@(posedge clk_i);
			end
			check_value("instr_ret_o pulses", 32'(ret_this), 32'(exp_kind != K_ILLEGAL));
			dut_retires += ret_this;
		end

		@(negedge clk_i);
		instr_valid_i = 1'b0;
		#40;
		check_bit("instr_ret_o", instr_ret_o, 1'b0);
		check_value("retire count", 32'(dut_retires), 32'(model_retires));
		$display("Decode stage test done: %0d instructions, %0d retired, %0d errors.",
			NUM_INSTR, dut_retires, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
design/id_pkg.sv
design/id_decoder.sv
design/id_regfile.sv
design/id_operand_mux.sv
design/id_wb_fsm.sv
design/id_stage.sv
tests/tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Compiles and runs the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_id_stage -Mdir obj_dir -o sim_tb_id_stage
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
